// File: pkt_proc_params.svh
`ifndef PKT_PROC_PARAMS_SVH
`define PKT_PROC_PARAMS_SVH

// ====================
// Datapath sizing
// ====================

// Ingress pipelines, and table peers (management plus one per pipeline)
`define PP_NUM_PORTS  2
`define PP_NUM_PEERS  3

// 64 table entries
`define PP_TBL_AW     6

// Lookup input FIFO, power of two
`define PP_FIFO_DEPTH 4

// ====================
// Register map
// ====================

`define PP_REG_CTRL      12'h000
`define PP_REG_MISS_PORT 12'h004
`define PP_REG_TSTAMP    12'h008
`define PP_REG_DROPS     12'h00C

// Table window, one word per entry
`define PP_TBL_BASE      12'h100

`endif

// File: pkt_proc_pkg.sv
`include "pkt_proc_params.svh"

package pkt_proc_pkg;

    // ====================
    // Ingress
    // ====================

    // One header word per ingress strobe
    typedef struct packed {
        logic [7:0] dst_key;
        logic [5:0] dscp;
        logic [7:0] proto;
        logic [9:0] pkt_id;
    } pkt_hdr_t;

    // ====================
    // Match table
    // ====================

    // Field view used by the lookup pipes
    typedef struct packed {
        logic        valid;
        logic        drop;
        logic [1:0]  key_tag;      // Top two bits of dst_key
        logic [3:0]  egress_port;
        logic [5:0]  new_dscp;
        logic [17:0] spare;
    } tbl_fields_t;

    // Management sees the raw word, the pipes see the fields
    typedef union packed {
        logic [31:0] raw;
        tbl_fields_t fld;
    } tbl_entry_u;

    // Request from one arbiter peer
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [`PP_TBL_AW-1:0] addr;
        logic [31:0]           wdata;
    } tbl_req_t;

    // ====================
    // Egress
    // ====================

    typedef struct packed {
        logic [9:0]  pkt_id;
        logic [3:0]  egress_port;
        logic [5:0]  dscp;
        logic        hit;
        logic        drop;
        logic [31:0] tstamp;
    } egr_meta_t;

endpackage

// File: table_mem.sv
`timescale 1ns/1ps
`include "pkt_proc_params.svh"

module table_mem (
    input  logic                     axil_if,
    input  logic                     we,
    input  logic [`PP_TBL_AW-1:0]    addr,
    input  logic [31:0]              wdata,
    output pkt_proc_pkg::tbl_entry_u rdata
);

    localparam int DEPTH = 1 << `PP_TBL_AW;

    // Match table storage
    logic [31:0] mem [DEPTH];

    // ====================
    // Single port access
    // ====================

    // Registered read, old data returned on a write cycle
    always_ff @(posedge axil_if) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: table_arbiter.sv
`timescale 1ns/1ps
`include "pkt_proc_params.svh"

module table_arbiter (
    input  logic                     axil_if,
    input  logic                     rst_n,
    input  pkt_proc_pkg::tbl_req_t   req    [`PP_NUM_PEERS],
    output logic                     gnt    [`PP_NUM_PEERS],
    output logic                     rvalid [`PP_NUM_PEERS],
    output pkt_proc_pkg::tbl_entry_u rdata
);
    import pkt_proc_pkg::*;

    logic [1:0] last;
    logic [1:0] cand;
    logic [1:0] sel;
    logic       found;
    tbl_req_t   win;
    logic [1:0] rd_owner;
    logic       rd_pend;

    // ====================
    // Round robin pick
    // ====================

    // Search starts at the peer after the last one granted
    always_comb begin
        sel   = 2'd0;
        found = 1'b0;
        cand  = last;
        for (int i = 0; i < `PP_NUM_PEERS; i++) begin
            cand = (cand == 2'(`PP_NUM_PEERS - 1)) ? 2'd0 : cand + 2'd1;
            if (!found && req[cand].req) begin
                sel   = cand;
                found = 1'b1;
            end
        end
    end

    assign win = req[sel];

    always_comb begin
        for (int k = 0; k < `PP_NUM_PEERS; k++) begin
            gnt[k]    = found && (sel == 2'(k));
            rvalid[k] = rd_pend && (rd_owner == 2'(k));
        end
    end

    // ====================
    // Read tracking
    // ====================

    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            last    <= 2'(`PP_NUM_PEERS - 1);
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= found && !win.we;
            if (found) begin
                last <= sel;
            end
        end
    end

    // Owner only matters while rd_pend is set
    always_ff @(posedge axil_if) begin
        if (found) begin
            rd_owner <= sel;
        end
    end

    table_mem mem_i (
        .axil_if (axil_if),
        .we      (found && win.we),
        .addr    (win.addr),
        .wdata   (win.wdata),
        .rdata   (rdata)
    );

endmodule

// File: lookup_pipe.sv
`timescale 1ns/1ps
`include "pkt_proc_params.svh"

module lookup_pipe (
    input  logic                     axil_if,
    input  logic                     rst_n,
    input  logic                     hdr_valid,
    input  pkt_proc_pkg::pkt_hdr_t   hdr,
    input  logic [31:0]              tstamp,
    input  logic [3:0]               miss_port,
    output pkt_proc_pkg::tbl_req_t   tbl_req,
    input  logic                     tbl_gnt,
    input  logic                     tbl_rvalid,
    input  pkt_proc_pkg::tbl_entry_u tbl_rdata,
    output logic                     out_valid,
    output pkt_proc_pkg::egr_meta_t  out_meta,
    output logic                     drop_pulse,
    output logic                     overflow_pulse
);
    import pkt_proc_pkg::*;

    localparam int PW = $clog2(`PP_FIFO_DEPTH);

    // Input FIFO, header plus arrival timestamp
    pkt_hdr_t      fifo_hdr [`PP_FIFO_DEPTH];
    logic [31:0]   fifo_ts  [`PP_FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   fifo_cnt;
    logic          fifo_full;
    logic          fifo_empty;
    logic          push;

    // Shadow queue for granted headers awaiting table data
    pkt_hdr_t      shq_hdr [2];
    logic [31:0]   shq_ts  [2];
    logic          shq_wr;
    logic          shq_rd;
    logic [1:0]    shq_cnt;

    pkt_hdr_t      cur_hdr;
    logic          hit;

    // ====================
    // Input FIFO
    // ====================

    assign fifo_full      = (fifo_cnt == (PW+1)'(`PP_FIFO_DEPTH));
    assign fifo_empty     = (fifo_cnt == '0);
    assign push           = hdr_valid && !fifo_full;
    assign overflow_pulse = hdr_valid && fifo_full;

    always_ff @(posedge axil_if) begin
        if (push) begin
            fifo_hdr[wr_ptr] <= hdr;
            fifo_ts[wr_ptr]  <= tstamp;
        end
    end

    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (tbl_gnt) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, tbl_gnt})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    // Head entry reads the table, popped on grant
    assign tbl_req = '{
        req:   !fifo_empty && (shq_cnt != 2'd2),
        we:    1'b0,
        addr:  fifo_hdr[rd_ptr].dst_key[`PP_TBL_AW-1:0],
        wdata: 32'h0
    };

    // ====================
    // Shadow queue
    // ====================

    always_ff @(posedge axil_if) begin
        if (tbl_gnt) begin
            shq_hdr[shq_wr] <= fifo_hdr[rd_ptr];
            shq_ts[shq_wr]  <= fifo_ts[rd_ptr];
        end
    end

    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            shq_wr  <= 1'b0;
            shq_rd  <= 1'b0;
            shq_cnt <= 2'd0;
        end else begin
            if (tbl_gnt) begin
                shq_wr <= ~shq_wr;
            end
            if (tbl_rvalid) begin
                shq_rd <= ~shq_rd;
            end
            case ({tbl_gnt, tbl_rvalid})
                2'b10:   shq_cnt <= shq_cnt + 2'd1;
                2'b01:   shq_cnt <= shq_cnt - 2'd1;
                default: shq_cnt <= shq_cnt;
            endcase
        end
    end

    // ====================
    // Action stage
    // ====================

    assign cur_hdr = shq_hdr[shq_rd];
    assign hit     = tbl_rdata.fld.valid && (tbl_rdata.fld.key_tag == cur_hdr.dst_key[7:6]);

    always_ff @(posedge axil_if) begin
        if (tbl_rvalid) begin
            out_meta.pkt_id <= cur_hdr.pkt_id;
            out_meta.tstamp <= shq_ts[shq_rd];
            out_meta.hit    <= hit;
            if (hit) begin
                out_meta.egress_port <= tbl_rdata.fld.egress_port;
                out_meta.dscp        <= tbl_rdata.fld.new_dscp;
                out_meta.drop        <= tbl_rdata.fld.drop;
            end else begin
                // Miss forwards unchanged to the miss port
                out_meta.egress_port <= miss_port;
                out_meta.dscp        <= cur_hdr.dscp;
                out_meta.drop        <= 1'b0;
            end
        end
    end

    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= tbl_rvalid;
        end
    end

    assign drop_pulse = out_valid && out_meta.drop;

endmodule

// File: mgmt_regs.sv
`timescale 1ns/1ps
`include "pkt_proc_params.svh"

module mgmt_regs (
    input  logic                     axil_if,
    input  logic                     rst_n,
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  logic [11:0]              reg_addr,
    input  logic [31:0]              reg_wdata,
    output logic [31:0]              reg_rdata,
    output logic                     reg_rd_valid,
    output logic                     reg_busy,
    output logic [31:0]              tstamp,
    output logic [3:0]               miss_port,
    input  logic                     drop_pulse     [`PP_NUM_PORTS],
    input  logic                     overflow_pulse [`PP_NUM_PORTS],
    output pkt_proc_pkg::tbl_req_t   tbl_req,
    input  logic                     tbl_gnt,
    input  logic                     tbl_rvalid,
    input  pkt_proc_pkg::tbl_entry_u tbl_rdata
);

    logic                  ts_en;
    logic                  overflow;
    logic [31:0]           drops;
    logic [31:0]           drop_inc;
    logic                  ovf_any;
    logic [31:0]           reg_mux;
    logic                  tbl_sel;
    logic                  pend_req;
    logic                  pend_we;
    logic [`PP_TBL_AW-1:0] pend_addr;
    logic [31:0]           pend_wdata;
    logic                  rd_wait;

    assign tbl_sel = (reg_addr >= `PP_TBL_BASE);

    // ====================
    // Status and counters
    // ====================

    // Both pipes may drop in the same cycle
    always_comb begin
        drop_inc = '0;
        ovf_any  = 1'b0;
        for (int i = 0; i < `PP_NUM_PORTS; i++) begin
            drop_inc = drop_inc + {31'd0, drop_pulse[i]};
            ovf_any  = ovf_any | overflow_pulse[i];
        end
    end

    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            ts_en     <= 1'b0;
            overflow  <= 1'b0;
            miss_port <= '0;
            tstamp    <= '0;
            drops     <= '0;
        end else begin
            if (reg_wr && reg_addr == `PP_REG_CTRL) begin
                ts_en <= reg_wdata[0];
            end
            if (reg_wr && reg_addr == `PP_REG_MISS_PORT) begin
                miss_port <= reg_wdata[3:0];
            end
            // Sticky, write one to bit 1 clears
            if (ovf_any) begin
                overflow <= 1'b1;
            end else if (reg_wr && reg_addr == `PP_REG_CTRL && reg_wdata[1]) begin
                overflow <= 1'b0;
            end
            if (ts_en) begin
                tstamp <= tstamp + 32'd1;
            end
            drops <= drops + drop_inc;
        end
    end

    always_comb begin
        case (reg_addr)
            `PP_REG_CTRL:      reg_mux = {30'd0, overflow, ts_en};
            `PP_REG_MISS_PORT: reg_mux = {28'd0, miss_port};
            `PP_REG_TSTAMP:    reg_mux = tstamp;
            `PP_REG_DROPS:     reg_mux = drops;
            default:           reg_mux = '0;
        endcase
    end

    // ====================
    // Table access path
    // ====================

    assign tbl_req  = '{req: pend_req, we: pend_we, addr: pend_addr, wdata: pend_wdata};
    assign reg_busy = pend_req || rd_wait;

    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            pend_req     <= 1'b0;
            rd_wait      <= 1'b0;
            reg_rd_valid <= 1'b0;
        end else begin
            reg_rd_valid <= (reg_rd && !tbl_sel) || (rd_wait && tbl_rvalid);
            // Request held until the arbiter takes it
            if ((reg_wr || reg_rd) && tbl_sel) begin
                pend_req <= 1'b1;
            end else if (tbl_gnt) begin
                pend_req <= 1'b0;
            end
            if (tbl_gnt && !pend_we) begin
                rd_wait <= 1'b1;
            end else if (tbl_rvalid) begin
                rd_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge axil_if) begin
        if ((reg_wr || reg_rd) && tbl_sel) begin
            pend_we    <= reg_wr;
            pend_addr  <= reg_addr[`PP_TBL_AW+1:2];
            pend_wdata <= reg_wdata;
        end
        if (reg_rd && !tbl_sel) begin
            reg_rdata <= reg_mux;
        end else if (rd_wait && tbl_rvalid) begin
            reg_rdata <= tbl_rdata.raw;
        end
    end

endmodule

// File: pkt_proc_top.sv
`timescale 1ns/1ps
`include "pkt_proc_params.svh"

module pkt_proc_top (
    input  logic                    axil_if,
    input  logic                    rst_n,
    input  logic                    hdr_valid [`PP_NUM_PORTS],
    input  pkt_proc_pkg::pkt_hdr_t  hdr       [`PP_NUM_PORTS],
    output logic                    out_valid [`PP_NUM_PORTS],
    output pkt_proc_pkg::egr_meta_t out_meta  [`PP_NUM_PORTS],
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  logic [11:0]             reg_addr,
    input  logic [31:0]             reg_wdata,
    output logic [31:0]             reg_rdata,
    output logic                    reg_rd_valid,
    output logic                    reg_busy
);
    import pkt_proc_pkg::*;

    // Peer 0 is management, peers 1 and up are the pipes
    tbl_req_t    tbl_req    [`PP_NUM_PEERS];
    logic        tbl_gnt    [`PP_NUM_PEERS];
    logic        tbl_rvalid [`PP_NUM_PEERS];
    tbl_entry_u  tbl_rdata;

    logic [31:0] tstamp;
    logic [3:0]  miss_port;
    logic        drop_pulse     [`PP_NUM_PORTS];
    logic        overflow_pulse [`PP_NUM_PORTS];

    // ====================
    // Shared table
    // ====================

    table_arbiter arb_i (
        .axil_if (axil_if),
        .rst_n   (rst_n),
        .req     (tbl_req),
        .gnt     (tbl_gnt),
        .rvalid  (tbl_rvalid),
        .rdata   (tbl_rdata)
    );

    mgmt_regs regs_i (
        .axil_if        (axil_if),
        .rst_n          (rst_n),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .reg_rd_valid   (reg_rd_valid),
        .reg_busy       (reg_busy),
        .tstamp         (tstamp),
        .miss_port      (miss_port),
        .drop_pulse     (drop_pulse),
        .overflow_pulse (overflow_pulse),
        .tbl_req        (tbl_req[0]),
        .tbl_gnt        (tbl_gnt[0]),
        .tbl_rvalid     (tbl_rvalid[0]),
        .tbl_rdata      (tbl_rdata)
    );

    // ====================
    // Ingress pipelines
    // ====================

    for (genvar i = 0; i < `PP_NUM_PORTS; i++) begin : g_pipe
        lookup_pipe pipe_i (
            .axil_if        (axil_if),
            .rst_n          (rst_n),
            .hdr_valid      (hdr_valid[i]),
            .hdr            (hdr[i]),
            .tstamp         (tstamp),
            .miss_port      (miss_port),
            .tbl_req        (tbl_req[i+1]),
            .tbl_gnt        (tbl_gnt[i+1]),
            .tbl_rvalid     (tbl_rvalid[i+1]),
            .tbl_rdata      (tbl_rdata),
            .out_valid      (out_valid[i]),
            .out_meta       (out_meta[i]),
            .drop_pulse     (drop_pulse[i]),
            .overflow_pulse (overflow_pulse[i])
        );
    end

endmodule

// File: pkt_proc_assertions.sv
`timescale 1ns/1ps
`include "pkt_proc_params.svh"

module pkt_proc_assertions (
    input logic                   axil_if,
    input logic                   rst_n,
    input logic [2:0]             gnt,
    input logic [2:0]             req_vec,
    input logic [2:0]             rvalid,
    input logic [2:0]             rd_gnt,
    input logic                   push,
    input logic                   out_valid,
    input pkt_proc_pkg::tbl_req_t req_word,
    input logic                   req_gnt
);

    logic seen_push;

    // Set once the pipe FIFO has taken its first header
    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            seen_push <= 1'b0;
        end else if (push) begin
            seen_push <= 1'b1;
        end
    end

    // ====================
    // Arbiter
    // ====================

    // One grant at most, only to a requester, and none lost while someone asks
    gnt_legal: assert property (@(posedge axil_if) disable iff (!rst_n)
        $onehot0(gnt) && ((gnt & ~req_vec) == 3'b000)
        && ((req_vec == 3'b000) || (gnt != 3'b000)))
        else $error("table grant is not one-hot, not requested, or missing");

    rvalid_after_read: assert property (@(posedge axil_if) disable iff (!rst_n)
        rvalid == $past(rd_gnt))
        else $error("rvalid does not follow a read grant by one cycle");

    // ====================
    // Lookup pipe
    // ====================

    out_after_push: assert property (@(posedge axil_if) disable iff (!rst_n)
        out_valid |-> seen_push)
        else $error("result before any header was written");

    req_held: assert property (@(posedge axil_if) disable iff (!rst_n)
        (req_word.req && !req_gnt) |=> $stable(req_word))
        else $error("table request changed before grant");

endmodule

bind table_arbiter pkt_proc_assertions arb_chk (
    .axil_if   (axil_if),
    .rst_n     (rst_n),
    .gnt       ({gnt[2], gnt[1], gnt[0]}),
    .req_vec   ({req[2].req, req[1].req, req[0].req}),
    .rvalid    ({rvalid[2], rvalid[1], rvalid[0]}),
    .rd_gnt    ({gnt[2] && !req[2].we, gnt[1] && !req[1].we, gnt[0] && !req[0].we}),
    .push      (1'b0),
    .out_valid (1'b0),
    .req_word  ('0),
    .req_gnt   (1'b0)
);

bind lookup_pipe pkt_proc_assertions pipe_chk (
    .axil_if   (axil_if),
    .rst_n     (rst_n),
    .gnt       (3'b000),
    .req_vec   (3'b000),
    .rvalid    (3'b000),
    .rd_gnt    (3'b000),
    .push      (push),
    .out_valid (out_valid),
    .req_word  (tbl_req),
    .req_gnt   (tbl_gnt)
);

// File: tb_pkt_proc.sv
`timescale 1ns/1ps
`include "pkt_proc_params.svh"

module tb_pkt_proc;
    import pkt_proc_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_ROWS   = 13;
    localparam int NUM_ENT    = 4;

    typedef struct {
        string      name;
        int         port;
        bit         same_cycle;
        int         grp;
        logic [7:0] key;
        logic [5:0] dscp;
        logic [3:0] exp_port;
        logic [5:0] exp_dscp;
        bit         exp_hit;
        bit         exp_drop;
    } row_t;

    logic        axil_if;
    logic        rst_n;
    logic        hdr_valid [`PP_NUM_PORTS];
    pkt_hdr_t    hdr       [`PP_NUM_PORTS];
    logic        out_valid [`PP_NUM_PORTS];
    egr_meta_t   out_meta  [`PP_NUM_PORTS];
    logic        reg_wr;
    logic        reg_rd;
    logic [11:0] reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        reg_rd_valid;
    logic        reg_busy;

    row_t        rows [NUM_ROWS];
    int          ent_idx  [NUM_ENT];
    logic [31:0] ent_word [NUM_ENT];
    int          exp_row [`PP_NUM_PORTS][$];
    logic [9:0]  exp_id  [`PP_NUM_PORTS][$];
    logic [31:0] last_ts [`PP_NUM_PORTS];
    logic [31:0] max_ts;
    logic [31:0] lfsr;
    logic [31:0] rd_val;
    bit          ts_mode;
    int          errors;
    int          tests;
    int          failed;
    int          drops_sent;

    pkt_proc_top dut_i (.*);

    always #(CLK_PERIOD / 2) axil_if = ~axil_if;

    // Limit scales with the number of rows
    initial begin
        #(CLK_PERIOD * (50 * NUM_ROWS + 200));
        $display("watchdog expired before the test sequence finished");
        $display("TEST FAIL");
        $finish;
    end

    // ====================
    // Helpers
    // ====================

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Table word layout from the entry field order, msb first
    function automatic logic [31:0] make_entry(input bit v, input bit d, input logic [1:0] tag,
                                               input logic [3:0] port, input logic [5:0] dscp);
        return {v, d, tag, port, dscp, 18'h0};
    endfunction

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) begin
            failed++;
            $display("test %s FAILED", name);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    task automatic mgmt_access(input bit wr, input logic [11:0] addr, input logic [31:0] data);
        @(posedge axil_if);
        reg_wr    <= wr;
        reg_rd    <= !wr;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge axil_if);
        reg_wr <= 1'b0;
        reg_rd <= 1'b0;
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
        int n;
        n = 0;
        mgmt_access(1'b1, addr, data);
        @(negedge axil_if);
        while (reg_busy && n < 100) begin
            @(negedge axil_if);
            n++;
        end
        if (reg_busy) begin
            $display("management write to %0h never completed", addr);
            errors++;
        end
    endtask

    task automatic reg_read(input logic [11:0] addr, output logic [31:0] data);
        int n;
        n = 0;
        mgmt_access(1'b0, addr, 32'h0);
        @(negedge axil_if);
        while (!reg_rd_valid && n < 100) begin
            @(negedge axil_if);
            n++;
        end
        if (!reg_rd_valid) begin
            $display("management read of %0h never returned data", addr);
            errors++;
        end
        check("busy_at_rd_valid", 32'h0, {31'h0, reg_busy});
        data = reg_rdata;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_row[0].size() != 0 || exp_row[1].size() != 0) && n < 200) begin
            @(negedge axil_if);
            n++;
        end
        if (n == 200) begin
            $display("results still outstanding after waiting 200 cycles");
            errors++;
        end
    endtask

    task automatic send_row(input int r);
        int       p;
        pkt_hdr_t h;
        p = rows[r].port;
        h = '{dst_key: rows[r].key, dscp: rows[r].dscp,
              proto: 8'(rand_bits(8)), pkt_id: 10'(rand_bits(10))};
        hdr_valid[p] <= 1'b1;
        hdr[p]       <= h;
        exp_row[p].push_back(r);
        exp_id[p].push_back(h.pkt_id);
        if (rows[r].exp_drop) begin
            drops_sent++;
        end
    endtask

    // ====================
    // Result monitor
    // ====================

    always @(negedge axil_if) begin
        int r;
        int e0;
        if (rst_n) begin
            for (int p = 0; p < `PP_NUM_PORTS; p++) begin
                if (out_valid[p] && exp_row[p].size() == 0) begin
                    $display("unexpected result on port %0d", p);
                    errors++;
                end else if (out_valid[p]) begin
                    e0 = errors;
                    r = exp_row[p].pop_front();
                    check({rows[r].name, ".pkt_id"}, 32'(exp_id[p].pop_front()),
                          32'(out_meta[p].pkt_id));
                    check({rows[r].name, ".port"}, 32'(rows[r].exp_port),
                          32'(out_meta[p].egress_port));
                    check({rows[r].name, ".dscp"}, 32'(rows[r].exp_dscp),
                          32'(out_meta[p].dscp));
                    check({rows[r].name, ".hit"}, 32'(rows[r].exp_hit),
                          32'(out_meta[p].hit));
                    check({rows[r].name, ".drop"}, 32'(rows[r].exp_drop),
                          32'(out_meta[p].drop));
                    if (!ts_mode) begin
                        check({rows[r].name, ".tstamp"}, 32'h0, out_meta[p].tstamp);
                    end else if (out_meta[p].tstamp <= last_ts[p]) begin
                        // Headers on one port enter at least 3 cycles apart
                        $display("timestamp did not advance on port %0d", p);
                        errors++;
                    end
                    last_ts[p] = out_meta[p].tstamp;
                    if (out_meta[p].tstamp > max_ts) begin
                        max_ts = out_meta[p].tstamp;
                    end
                    finish_test(rows[r].name, e0);
                end
            end
        end
    end

    // ====================
    // Sequence
    // ====================

    initial begin
        int e0;
        axil_if = 1'b0;
        rst_n <= 1'b0;
        reg_wr <= 1'b0;
        reg_rd <= 1'b0;
        reg_addr <= '0;
        reg_wdata <= '0;
        for (int p = 0; p < `PP_NUM_PORTS; p++) begin
            hdr_valid[p] <= 1'b0;
            hdr[p] <= '0;
            last_ts[p] = '0;
        end
        lfsr = 32'h3e65;
        max_ts = '0;
        ts_mode = 1'b0;
        errors = 0;
        tests = 0;
        failed = 0;
        drops_sent = 0;

        // Entries: forward, second forward, invalid, drop
        ent_idx[0] = 5;  ent_word[0] = make_entry(1, 0, 2'b01, 4'd3, 6'd10);
        ent_idx[1] = 9;  ent_word[1] = make_entry(1, 0, 2'b10, 4'd7, 6'd33);
        ent_idx[2] = 12; ent_word[2] = make_entry(0, 0, 2'b00, 4'd2, 6'd40);
        ent_idx[3] = 20; ent_word[3] = make_entry(1, 1, 2'b11, 4'd1, 6'd0);

        rows[0]  = '{"hit_p0",        0, 0, 0, 8'h45, 6'd3,  4'd3,  6'd10, 1, 0};
        rows[1]  = '{"hit_p1",        1, 0, 0, 8'h45, 6'd4,  4'd3,  6'd10, 1, 0};
        rows[2]  = '{"tag_miss",      0, 0, 0, 8'h49, 6'd7,  4'd9,  6'd7,  0, 0};
        rows[3]  = '{"invalid_miss",  1, 0, 0, 8'h0C, 6'd12, 4'd9,  6'd12, 0, 0};
        rows[4]  = '{"drop_p0",       0, 0, 0, 8'hD4, 6'd1,  4'd1,  6'd0,  1, 1};
        rows[5]  = '{"drop_p1",       1, 1, 0, 8'hD4, 6'd2,  4'd1,  6'd0,  1, 1};
        rows[6]  = '{"hit2_p1",       1, 0, 0, 8'h89, 6'd5,  4'd7,  6'd33, 1, 0};
        rows[7]  = '{"miss_new_port", 0, 0, 1, 8'h49, 6'd20, 4'd14, 6'd20, 0, 0};
        rows[8]  = '{"inval_new_port", 1, 0, 1, 8'h0C, 6'd21, 4'd14, 6'd21, 0, 0};
        rows[9]  = '{"drop_both_p0",  0, 0, 1, 8'hD4, 6'd9,  4'd1,  6'd0,  1, 1};
        rows[10] = '{"drop_both_p1",  1, 1, 1, 8'hD4, 6'd9,  4'd1,  6'd0,  1, 1};
        rows[11] = '{"hit_ts_p0",     0, 0, 1, 8'h89, 6'd0,  4'd7,  6'd33, 1, 0};
        rows[12] = '{"hit_ts_p1",     1, 0, 1, 8'h45, 6'd63, 4'd3,  6'd10, 1, 0};

        repeat (4) @(posedge axil_if);
        rst_n <= 1'b1;
        @(negedge axil_if);
        e0 = errors;
        check("reset_busy", 32'h0, {31'h0, reg_busy});
        check("reset_rd_valid", 32'h0, {31'h0, reg_rd_valid});
        check("reset_out_valid", 32'h0, {30'h0, out_valid[1], out_valid[0]});
        finish_test("reset_state", e0);

        // Program the table and read each word back
        reg_write(`PP_REG_MISS_PORT, 32'd9);
        for (int k = 0; k < NUM_ENT; k++) begin
            e0 = errors;
            reg_write(`PP_TBL_BASE + 12'(4 * ent_idx[k]), ent_word[k]);
            reg_read(`PP_TBL_BASE + 12'(4 * ent_idx[k]), rd_val);
            check("table_readback", ent_word[k], rd_val);
            finish_test("table_rw", e0);
        end

        for (int g = 0; g < 2; g++) begin
            if (g == 1) begin
                reg_write(`PP_REG_MISS_PORT, 32'd14);
                reg_write(`PP_REG_CTRL, 32'h1);
                ts_mode = 1'b1;
            end
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (rows[r].grp == g) begin
                    if (!rows[r].same_cycle) begin
                        @(posedge axil_if);
                        hdr_valid[0] <= 1'b0;
                        hdr_valid[1] <= 1'b0;
                        repeat (2) @(posedge axil_if);
                    end
                    send_row(r);
                    // Table reads compete with the traffic
                    if (g == 1 && r % 2 == 0) begin
                        @(posedge axil_if);
                        hdr_valid[0] <= 1'b0;
                        hdr_valid[1] <= 1'b0;
                        e0 = errors;
                        reg_read(`PP_TBL_BASE + 12'(4 * ent_idx[r % NUM_ENT]), rd_val);
                        check("table_read_busy", ent_word[r % NUM_ENT], rd_val);
                        finish_test("table_read_under_traffic", e0);
                    end
                end
            end
            @(posedge axil_if);
            hdr_valid[0] <= 1'b0;
            hdr_valid[1] <= 1'b0;
            drain();
        end

        e0 = errors;
        reg_read(`PP_REG_DROPS, rd_val);
        check("drop_count", drops_sent, rd_val);
        reg_read(`PP_REG_CTRL, rd_val);
        check("overflow_flag", 32'h0, {31'h0, rd_val[1]});
        reg_read(`PP_REG_TSTAMP, rd_val);
        if (rd_val <= max_ts) begin
            $display("timestamp register %0d is not above result stamp %0d", rd_val, max_ts);
            errors++;
        end
        finish_test("status_regs", e0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
pkt_proc_pkg.sv
table_mem.sv
table_arbiter.sv
lookup_pipe.sv
mgmt_regs.sv
pkt_proc_top.sv
pkt_proc_assertions.sv
tb_pkt_proc.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_pkt_proc -f files.f

out=$(./obj_dir/Vtb_pkt_proc)
echo "$out"

if grep -q "TEST PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi
